/* flist.f */
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/fetch_stage.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu.sv
tests/cpu_assertions.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	import cpu_isa_pkg::*;

	localparam word_t RESET_PC = 32'h0000_0200;
	localparam word_t FILL_KEY = 32'h9e37_79b9;
	localparam word_t WIN_BASE = 32'h0000_0400;
	localparam word_t DUMP_BASE = 32'h0000_0800;
	localparam word_t MARKER_ADDR = 32'h0000_0ffc;
	localparam word_t NOP_WORD = 32'hfc00_0000;
	localparam int BODY_LEN = 200;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 1024;
	localparam int TIMEOUT_CYCLES = 4 * (BODY_LEN + 31) + 100;

	logic  clock;
	logic  rst;
	logic  run;
	word_t im_address;
	word_t im_data;
	logic  dm_enable;
	logic  dm_write;
	word_t dm_address;
	word_t dm_wdata;
	word_t dm_rdata;
	logic  alu_overflow;
	logic  program_done;
	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	int    seed;
	int    cycle_count;
	int    failed_tests;
	logic  timed_out;

	cpu #(
		.RESET_PC(RESET_PC)
	) UUT (
		.clock(clock),
		.rst(rst),
		.run(run),
		.im_address(im_address),
		.im_data(im_data),
		.dm_enable(dm_enable),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata),
		.alu_overflow(alu_overflow)
	);

	cpu_checker #(
		.RESET_PC(RESET_PC),
		.FILL_KEY(FILL_KEY),
		.DUMP_BASE(DUMP_BASE),
		.MARKER_ADDR(MARKER_ADDR),
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) CHECK (
		.clock(clock),
		.rst(rst),
		.run(run),
		.im_address(im_address),
		.dm_enable(dm_enable),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.alu_overflow(alu_overflow),
		.program_done(program_done)
	);

	bind cpu cpu_assertions ASSERT (
		.clock(clock),
		.rst(rst),
		.run(run),
		.dm_enable(dm_enable),
		.alu_overflow(alu_overflow),
		.im_address(im_address)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// instruction memory, no-ops outside the program
	always @(*) begin
		if ((im_address - RESET_PC) < 4 * IMEM_WORDS)
			im_data = imem[(im_address - RESET_PC) >> 2];
		else
			im_data = NOP_WORD;
	end

	always @(*) dm_rdata = dmem[dm_address[11:2]];

	always @(posedge clock) begin
		if (dm_enable && dm_write)
			dmem[dm_address[11:2]] <= dm_wdata;
	end

	function automatic int roll(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t alu_word(input alu_fn_e fn, input int rt, input int ra, input int rb);
		return {OP_ALU, 5'(rt), 5'(ra), 5'(rb), 6'b0, fn};
	endfunction

	function automatic word_t imm_word(input op_e op, input int rt, input int ra,
		input logic [15:0] imm);
		return {op, 5'(rt), 5'(ra), imm};
	endfunction

	function automatic word_t jump_word(input logic [25:0] off);
		return {OP_J, off};
	endfunction

	task automatic build_program();
		int kind;
		int off;
		int last_load;
		last_load = 0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = NOP_WORD;
		for (int i = 0; i < BODY_LEN; i++) begin
			kind = roll(100);
			// forward targets stay inside the body
			off = 1 + roll(4);
			if (i + 1 + off > BODY_LEN)
				off = BODY_LEN - 1 - i;
			if (last_load != 0 && roll(2) == 0) begin
				// use the loaded register right away
				imem[i] = alu_word(alu_fn_e'(roll(6)), 1 + roll(7), last_load, roll(8));
				kind = -1;
			end else if (kind < 45)
				imem[i] = alu_word(alu_fn_e'(roll(6)), 1 + roll(7), roll(8), roll(8));
			else if (kind < 60)
				imem[i] = imm_word(OP_ADDI, 1 + roll(7), roll(8), 16'(roll(65536)));
			else if (kind < 73)
				imem[i] = imm_word(OP_LW, 1 + roll(7), 0, 16'(WIN_BASE + 4 * roll(64)));
			else if (kind < 83)
				imem[i] = imm_word(OP_SW, roll(8), 0, 16'(WIN_BASE + 4 * roll(64)));
			else if (kind < 95)
				imem[i] = imm_word(roll(2) ? OP_BNE : OP_BEQ, roll(8), roll(8), 16'(off));
			else
				imem[i] = jump_word(26'(off));
			last_load = (imem[i][31:26] == OP_LW) ? int'(imem[i][25:21]) : 0;
		end
		for (int r = 1; r < 32; r++)
			imem[BODY_LEN + r - 1] = imm_word(OP_SW, r, 0, 16'(DUMP_BASE + 4 * (r - 1)));
		imem[BODY_LEN + 31] = imm_word(OP_SW, 0, 0, 16'(MARKER_ADDR));
		imem[BODY_LEN + 32] = jump_word(26'h3ff_ffff);
	endtask

	initial begin
		seed = 32'h580d_8120;
		rst = 1'b1;
		run = 1'b0;
		cycle_count = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		build_program();
		for (int i = 0; i < DMEM_WORDS; i++)
			dmem[i] = word_t'(i << 2) ^ FILL_KEY;
		for (int i = 0; i < IMEM_WORDS; i++)
			CHECK.load_instr(i, imem[i]);
		CHECK.run_model();
		// run toggles while reset holds the walls
		repeat (5) begin
			run = (roll(4) != 0);
			@(negedge clock);
		end
		rst = 1'b0;
		while (!program_done && cycle_count < TIMEOUT_CYCLES) begin
			run = (roll(4) != 0);
			@(negedge clock);
			cycle_count++;
		end
		timed_out = !program_done;
		// a few more cycles to catch stray stores after the marker
		repeat (8) begin
			run = (roll(4) != 0);
			@(negedge clock);
		end
		if (timed_out)
			$display("program did not reach the marker store within %0d cycles", TIMEOUT_CYCLES);
		CHECK.report(failed_tests);
		if (!timed_out && failed_tests == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* tests/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker #(
	parameter cpu_isa_pkg::word_t RESET_PC = 32'h0000_0000,
	parameter cpu_isa_pkg::word_t FILL_KEY = 32'h0000_0000,
	parameter cpu_isa_pkg::word_t DUMP_BASE = 32'h0000_0800,
	parameter cpu_isa_pkg::word_t MARKER_ADDR = 32'h0000_0ffc,
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 1024
) (
	input  logic               clock,
	input  logic               rst,
	input  logic               run,
	input  cpu_isa_pkg::word_t im_address,
	input  logic               dm_enable,
	input  logic               dm_write,
	input  cpu_isa_pkg::word_t dm_address,
	input  cpu_isa_pkg::word_t dm_wdata,
	input  logic               alu_overflow,
	output logic               program_done
);

	import cpu_isa_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam int T_RESET = 0;
	localparam int T_BODY = 1;
	localparam int T_DUMP = 2;
	localparam int T_RUN = 3;
	localparam int T_OVF = 4;

	word_t prog [IMEM_WORDS];
	word_t exp_addr [$];
	word_t exp_data [$];
	int errs [NUM_TESTS] = '{default: 0};
	int model_stores = 0;
	int model_ovf = 0;
	int dut_stores = 0;
	int dut_ovf = 0;

	initial program_done = 1'b0;

	task load_instr(input int idx, input word_t w);
		prog[idx] = w;
	endtask

	function automatic word_t sign_extend(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// exact signed result differs from the wrapped one
	function automatic logic add_wraps(input word_t x, input word_t y);
		longint exact;
		exact = longint'($signed(x)) + longint'($signed(y));
		return exact != longint'($signed(x + y));
	endfunction

	function automatic logic sub_wraps(input word_t x, input word_t y);
		longint exact;
		exact = longint'($signed(x)) - longint'($signed(y));
		return exact != longint'($signed(x - y));
	endfunction

	// in-order model, one instruction per step
	task run_model();
		word_t regs [32];
		word_t mem [DMEM_WORDS];
		word_t pc;
		word_t pc_next;
		word_t w;
		word_t a;
		word_t b;
		word_t imm;
		word_t addr;
		logic [4:0] rt;
		int steps;
		logic halted;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			mem[i] = word_t'(i << 2) ^ FILL_KEY;
		pc = RESET_PC;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 10000) begin
			w = ((pc - RESET_PC) < 4 * IMEM_WORDS) ? prog[(pc - RESET_PC) >> 2] : '1;
			rt = w[25:21];
			a = regs[w[20:16]];
			b = regs[w[15:11]];
			imm = sign_extend(w[15:0]);
			pc_next = pc + 4;
			case (w[31:26])
				OP_ALU: begin
					case (w[4:0])
						FN_ADD: regs[rt] = a + b;
						FN_SUB: regs[rt] = a - b;
						FN_AND: regs[rt] = a & b;
						FN_OR:  regs[rt] = a | b;
						FN_XOR: regs[rt] = a ^ b;
						FN_SLT: regs[rt] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: regs[rt] = '0;
					endcase
					if ((w[4:0] == FN_ADD && add_wraps(a, b)) ||
					    (w[4:0] == FN_SUB && sub_wraps(a, b)))
						model_ovf++;
				end
				OP_ADDI: begin
					regs[rt] = a + imm;
					if (add_wraps(a, imm))
						model_ovf++;
				end
				OP_LW: regs[rt] = mem[(a + imm) >> 2];
				OP_SW: begin
					addr = a + imm;
					exp_addr.push_back(addr);
					exp_data.push_back(regs[rt]);
					mem[addr >> 2] = regs[rt];
					model_stores++;
				end
				OP_BEQ: if (regs[rt] == a) pc_next = pc + 4 + (imm << 2);
				OP_BNE: if (regs[rt] != a) pc_next = pc + 4 + (imm << 2);
				OP_J: begin
					pc_next = pc + 4 + {{4{w[25]}}, w[25:0], 2'b00};
					halted = (pc_next == pc);
				end
				default: ;
			endcase
			regs[0] = '0;
			pc = pc_next;
			steps++;
		end
	endtask

	task compare_store();
		word_t ea;
		word_t ed;
		int t;
		if (exp_addr.size() == 0) begin
			errs[T_RUN]++;
			$display("store to %h at %0t is beyond the predicted sequence", dm_address, $time);
		end else begin
			ea = exp_addr.pop_front();
			ed = exp_data.pop_front();
			if (dut_stores == 0)
				t = T_RESET;
			else if (ea >= DUMP_BASE && ea < DUMP_BASE + 31 * 4)
				t = T_DUMP;
			else
				t = T_BODY;
			if (dm_address !== ea) begin
				errs[t]++;
				$display("ERR %0t dm_address expected %h got %h", $time, ea, dm_address);
			end
			if (dm_wdata !== ed) begin
				errs[t]++;
				$display("ERR %0t dm_wdata expected %h got %h", $time, ed, dm_wdata);
			end
		end
		dut_stores++;
		if (dm_address == MARKER_ADDR)
			program_done = 1'b1;
	endtask

	always @(negedge rst) begin
		if (im_address !== RESET_PC) begin
			errs[T_RESET]++;
			$display("ERR %0t im_address expected %h got %h", $time, RESET_PC, im_address);
		end
		if (dm_enable !== 1'b0 || alu_overflow !== 1'b0) begin
			errs[T_RESET]++;
			$display("dm_enable or alu_overflow not low when reset ends at %0t", $time);
		end
	end

	always @(posedge clock) begin
		if (!rst) begin
			if (!run && dm_enable) begin
				errs[T_RUN]++;
				$display("data access presented at %0t while run is low", $time);
			end
			if (run && alu_overflow)
				dut_ovf++;
			if (run && dm_enable && dm_write)
				compare_store();
		end
	end

	task report(output int failed);
		string name;
		failed = 0;
		if (dut_stores == 0) begin
			errs[T_RESET]++;
			$display("no store was seen after reset");
		end
		if (dut_stores != model_stores) begin
			errs[T_RUN]++;
			$display("ERR %0t dm_write count expected %0d got %0d", $time, model_stores, dut_stores);
		end
		if (dut_ovf != model_ovf) begin
			errs[T_OVF]++;
			$display("ERR %0t alu_overflow cycles expected %0d got %0d", $time, model_ovf, dut_ovf);
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			case (t)
				T_RESET: name = "reset_start";
				T_BODY:  name = "store_sequence";
				T_DUMP:  name = "register_dump";
				T_RUN:   name = "run_gating";
				default: name = "overflow_count";
			endcase
			$display("test %-15s %s (%0d errors)", name, (errs[t] == 0) ? "ok" : "bad", errs[t]);
			if (errs[t] != 0)
				failed++;
		end
		$display("tests: %0d run, %0d passed, %0d failed, %0d stores, %0d overflow cycles",
			NUM_TESTS, NUM_TESTS - failed, failed, dut_stores, dut_ovf);
	endtask

endmodule

/* tests/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
	input logic               clock,
	input logic               rst,
	input logic               run,
	input logic               dm_enable,
	input logic               alu_overflow,
	input cpu_isa_pkg::word_t im_address
);

	// high once a reset edge has cleared the walls
	logic rst_prev = 1'b0;

	always @(posedge clock) begin
		rst_prev <= rst;
	end

	held_no_access: assert property (@(posedge clock) disable iff (rst) !run |-> !dm_enable)
		else $error("dm_enable high while run is low");

	reset_quiet: assert property (@(posedge clock) rst && rst_prev |-> !dm_enable && !alu_overflow)
		else $error("dm_enable or alu_overflow high during reset");

	pc_known: assert property (@(posedge clock) disable iff (rst) !$isunknown(im_address))
		else $error("im_address unknown after reset");

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ps

module cpu #(
	parameter cpu_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic               clock,
	input  logic               rst,
	input  logic               run,
	output cpu_isa_pkg::word_t im_address,
	input  cpu_isa_pkg::word_t im_data,
	output logic               dm_enable,
	output logic               dm_write,
	output cpu_isa_pkg::word_t dm_address,
	output cpu_isa_pkg::word_t dm_wdata,
	input  cpu_isa_pkg::word_t dm_rdata,
	output logic               alu_overflow
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	fetch_wall_t  fetch;
	decode_wall_t decode;
	exec_wall_t   exec;
	wb_t          wb;
	fwd_t         ex_fwd;
	fwd_t         mem_fwd;
	fwd_t         wb_fwd;
	logic         stall;
	logic         redirect;
	word_t        target_pc;
	reg_addr_t    ra_addr;
	reg_addr_t    rb_addr;
	reg_addr_t    rt_addr;
	word_t        ra_data;
	word_t        rb_data;
	word_t        rt_data;

	// write-back wall as the oldest bypass source
	assign wb_fwd = '{
		dest:      wb.dest,
		data:      wb.data,
		reg_write: wb.valid && wb.reg_write,
		is_load:   1'b0
	};

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) FETCH (
		.clock(clock),
		.rst(rst),
		.run(run),
		.stall(stall),
		.redirect(redirect),
		.target_pc(target_pc),
		.im_address(im_address),
		.im_data(im_data),
		.fetch(fetch)
	);

	decode_stage DECODE (
		.clock(clock),
		.rst(rst),
		.run(run),
		.fetch(fetch),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data),
		.ex_fwd(ex_fwd),
		.mem_fwd(mem_fwd),
		.wb_fwd(wb_fwd),
		.stall(stall),
		.redirect(redirect),
		.target_pc(target_pc),
		.decode(decode)
	);

	regfile REGFILE (
		.clock(clock),
		.rst(rst),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data),
		.wb(wb)
	);

	execute_stage EXECUTE (
		.clock(clock),
		.rst(rst),
		.run(run),
		.decode(decode),
		.ex_fwd(ex_fwd),
		.exec(exec)
	);

	memory_stage MEMORY (
		.clock(clock),
		.rst(rst),
		.run(run),
		.exec(exec),
		.dm_enable(dm_enable),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata),
		.mem_fwd(mem_fwd),
		.wb(wb),
		.alu_overflow(alu_overflow)
	);

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
	input  logic                     clock,
	input  logic                     rst,
	input  logic                     run,
	input  cpu_pipe_pkg::exec_wall_t exec,
	output logic                     dm_enable,
	output logic                     dm_write,
	output cpu_isa_pkg::word_t       dm_address,
	output cpu_isa_pkg::word_t       dm_wdata,
	input  cpu_isa_pkg::word_t       dm_rdata,
	output cpu_pipe_pkg::fwd_t       mem_fwd,
	output cpu_pipe_pkg::wb_t        wb,
	output logic                     alu_overflow
);

	import cpu_isa_pkg::*;

	word_t data;

	// no access while the pipeline is held
	assign dm_enable = run && exec.valid && (exec.mem_read || exec.mem_write);
	assign dm_write = exec.valid && exec.mem_write;
	assign dm_address = exec.result;
	assign dm_wdata = exec.st_data;

	assign data = exec.mem_read ? dm_rdata : exec.result;

	assign mem_fwd = '{
		dest:      exec.dest,
		data:      data,
		reg_write: exec.valid && exec.reg_write,
		is_load:   exec.mem_read
	};

	assign alu_overflow = exec.valid && exec.overflow;

	always_ff @(posedge clock) begin
		if (rst) begin
			wb.valid <= 1'b0;
		end else if (run) begin
			wb <= '{
				valid:     exec.valid,
				dest:      exec.dest,
				data:      data,
				reg_write: exec.reg_write
			};
		end
	end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic                       clock,
	input  logic                       rst,
	input  logic                       run,
	input  cpu_pipe_pkg::decode_wall_t decode,
	output cpu_pipe_pkg::fwd_t         ex_fwd,
	output cpu_pipe_pkg::exec_wall_t   exec
);

	import cpu_isa_pkg::*;

	alu_fn_e fn;
	word_t   sum;
	word_t   diff;
	word_t   result;
	logic    slt;
	logic    is_add;
	logic    is_sub;
	logic    add_ovf;
	logic    sub_ovf;
	logic    overflow;

	// immediate forms and addresses all add
	assign fn = (decode.op == OP_ALU) ? decode.fn : FN_ADD;

	assign sum = decode.ra_val + decode.opb;
	assign diff = decode.ra_val - decode.opb;
	assign slt = $signed(decode.ra_val) < $signed(decode.opb);

	always_comb begin
		case (fn)
			FN_ADD:  result = sum;
			FN_SUB:  result = diff;
			FN_AND:  result = decode.ra_val & decode.opb;
			FN_OR:   result = decode.ra_val | decode.opb;
			FN_XOR:  result = decode.ra_val ^ decode.opb;
			FN_SLT:  result = {{(XLEN-1){1'b0}}, slt};
			default: result = '0;
		endcase
	end

	assign is_add = (decode.op == OP_ALU && decode.fn == FN_ADD) || decode.op == OP_ADDI;
	assign is_sub = decode.op == OP_ALU && decode.fn == FN_SUB;
	// sign of result disagrees with operands
	assign add_ovf = (decode.ra_val[XLEN-1] == decode.opb[XLEN-1]) &&
		(sum[XLEN-1] != decode.ra_val[XLEN-1]);
	assign sub_ovf = (decode.ra_val[XLEN-1] != decode.opb[XLEN-1]) &&
		(diff[XLEN-1] != decode.ra_val[XLEN-1]);
	assign overflow = decode.valid && ((is_add && add_ovf) || (is_sub && sub_ovf));

	assign ex_fwd = '{
		dest:      decode.dest,
		data:      result,
		reg_write: decode.valid && decode.reg_write,
		is_load:   decode.mem_read
	};

	always_ff @(posedge clock) begin
		if (rst) begin
			exec.valid <= 1'b0;
		end else if (run) begin
			exec <= '{
				valid:     decode.valid,
				result:    result,
				st_data:   decode.st_data,
				dest:      decode.dest,
				reg_write: decode.reg_write,
				mem_read:  decode.mem_read,
				mem_write: decode.mem_write,
				overflow:  overflow
			};
		end
	end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic                       clock,
	input  logic                       rst,
	input  logic                       run,
	input  cpu_pipe_pkg::fetch_wall_t  fetch,
	output cpu_isa_pkg::reg_addr_t     ra_addr,
	output cpu_isa_pkg::reg_addr_t     rb_addr,
	output cpu_isa_pkg::reg_addr_t     rt_addr,
	input  cpu_isa_pkg::word_t         ra_data,
	input  cpu_isa_pkg::word_t         rb_data,
	input  cpu_isa_pkg::word_t         rt_data,
	input  cpu_pipe_pkg::fwd_t         ex_fwd,
	input  cpu_pipe_pkg::fwd_t         mem_fwd,
	input  cpu_pipe_pkg::fwd_t         wb_fwd,
	output logic                       stall,
	output logic                       redirect,
	output cpu_isa_pkg::word_t         target_pc,
	output cpu_pipe_pkg::decode_wall_t decode
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	op_e     op;
	alu_fn_e fn;
	word_t   imm_sext;
	word_t   pc_plus4;
	word_t   ra_val;
	word_t   rb_val;
	word_t   rt_val;
	logic    wr_reg;
	logic    rd_mem;
	logic    wr_mem;
	logic    use_ra;
	logic    use_rb;
	logic    use_rt;
	logic    use_imm;
	logic    taken;

	function automatic logic hit(input fwd_t f, input reg_addr_t addr);
		return f.reg_write && f.dest == addr;
	endfunction

	// youngest producer wins
	function automatic word_t pick(input reg_addr_t addr, input word_t rf_val);
		if (addr == '0)
			return '0;
		else if (hit(ex_fwd, addr))
			return ex_fwd.data;
		else if (hit(mem_fwd, addr))
			return mem_fwd.data;
		else if (hit(wb_fwd, addr))
			return wb_fwd.data;
		return rf_val;
	endfunction

	assign op = op_e'(fetch.instr[OPC_MSB:OPC_LSB]);
	assign fn = alu_fn_e'(fetch.instr[FN_MSB:FN_LSB]);
	assign rt_addr = fetch.instr[RT_MSB:RT_LSB];
	assign ra_addr = fetch.instr[RA_MSB:RA_LSB];
	assign rb_addr = fetch.instr[RB_MSB:RB_LSB];
	assign imm_sext = {{16{fetch.instr[IMM_MSB]}}, fetch.instr[IMM_MSB:IMM_LSB]};
	assign pc_plus4 = fetch.pc + 32'd4;

	always_comb begin
		ra_val = pick(ra_addr, ra_data);
		rb_val = pick(rb_addr, rb_data);
		rt_val = pick(rt_addr, rt_data);
	end

	always_comb begin
		wr_reg = 1'b0;
		rd_mem = 1'b0;
		wr_mem = 1'b0;
		use_ra = 1'b0;
		use_rb = 1'b0;
		use_rt = 1'b0;
		use_imm = 1'b0;
		case (op)
			OP_ALU: begin
				wr_reg = 1'b1;
				use_ra = 1'b1;
				use_rb = 1'b1;
			end
			OP_ADDI: begin
				wr_reg = 1'b1;
				use_ra = 1'b1;
				use_imm = 1'b1;
			end
			OP_LW: begin
				wr_reg = 1'b1;
				rd_mem = 1'b1;
				use_ra = 1'b1;
				use_imm = 1'b1;
			end
			OP_SW: begin
				wr_mem = 1'b1;
				use_ra = 1'b1;
				use_rt = 1'b1;
				use_imm = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				use_ra = 1'b1;
				use_rt = 1'b1;
			end
			default: ;
		endcase
	end

	// branch outcome from forwarded operands
	always_comb begin
		taken = 1'b0;
		target_pc = pc_plus4 + {imm_sext[29:0], 2'b00};
		case (op)
			OP_BEQ: taken = (rt_val == ra_val);
			OP_BNE: taken = (rt_val != ra_val);
			OP_J: begin
				taken = 1'b1;
				target_pc = pc_plus4 +
					{{4{fetch.instr[JOFF_MSB]}}, fetch.instr[JOFF_MSB:0], 2'b00};
			end
			default: ;
		endcase
	end

	// load in execute feeding a source here
	assign stall = fetch.valid && ex_fwd.is_load && ex_fwd.dest != '0 &&
		((use_ra && hit(ex_fwd, ra_addr)) ||
		 (use_rb && hit(ex_fwd, rb_addr)) ||
		 (use_rt && hit(ex_fwd, rt_addr)));

	assign redirect = fetch.valid && taken && !stall;

	always_ff @(posedge clock) begin
		if (rst) begin
			decode.valid <= 1'b0;
		end else if (run) begin
			decode <= '{
				valid:     fetch.valid && !stall,
				op:        op,
				fn:        fn,
				ra_val:    ra_val,
				opb:       use_imm ? imm_sext : rb_val,
				st_data:   rt_val,
				dest:      rt_addr,
				reg_write: wr_reg,
				mem_read:  rd_mem,
				mem_write: wr_mem
			};
		end
	end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic                  clock,
	input  logic                  rst,
	input  cpu_isa_pkg::reg_addr_t ra_addr,
	input  cpu_isa_pkg::reg_addr_t rb_addr,
	input  cpu_isa_pkg::reg_addr_t rt_addr,
	output cpu_isa_pkg::word_t    ra_data,
	output cpu_isa_pkg::word_t    rb_data,
	output cpu_isa_pkg::word_t    rt_data,
	input  cpu_pipe_pkg::wb_t     wb
);

	import cpu_isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && wb.reg_write && wb.dest != '0) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// r0 reads as zero
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
	parameter cpu_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      run,
	input  logic                      stall,
	input  logic                      redirect,
	input  cpu_isa_pkg::word_t        target_pc,
	output cpu_isa_pkg::word_t        im_address,
	input  cpu_isa_pkg::word_t        im_data,
	output cpu_pipe_pkg::fetch_wall_t fetch
);

	import cpu_isa_pkg::*;

	word_t pc;

	assign im_address = pc;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= RESET_PC;
			fetch.valid <= 1'b0;
		end else if (run) begin
			if (redirect) begin
				pc <= target_pc;
				// slot behind the branch is dropped
				fetch.valid <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 32'd4;
				fetch <= '{
					valid: 1'b1,
					pc:    pc,
					instr: im_data
				};
			end
		end
	end

endmodule

/* hdl/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	// fetch to decode
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} fetch_wall_t;

	// decode to execute
	typedef struct packed {
		logic      valid;
		op_e       op;
		alu_fn_e   fn;
		word_t     ra_val;
		word_t     opb;
		word_t     st_data;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
	} decode_wall_t;

	// execute to memory
	typedef struct packed {
		logic      valid;
		word_t     result;
		word_t     st_data;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      overflow;
	} exec_wall_t;

	// memory to register file
	typedef struct packed {
		logic      valid;
		reg_addr_t dest;
		word_t     data;
		logic      reg_write;
	} wb_t;

	// reg_write already includes the producer's valid
	typedef struct packed {
		reg_addr_t dest;
		word_t     data;
		logic      reg_write;
		logic      is_load;
	} fwd_t;

endpackage

/* hdl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// unlisted opcode values decode as no-operation
	typedef enum logic [5:0] {
		OP_ALU  = 6'h00,
		OP_ADDI = 6'h01,
		OP_LW   = 6'h02,
		OP_SW   = 6'h03,
		OP_BEQ  = 6'h04,
		OP_BNE  = 6'h05,
		OP_J    = 6'h06
	} op_e;

	typedef enum logic [4:0] {
		FN_ADD = 5'h00,
		FN_SUB = 5'h01,
		FN_AND = 5'h02,
		FN_OR  = 5'h03,
		FN_XOR = 5'h04,
		FN_SLT = 5'h05
	} alu_fn_e;

	// instruction field positions
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 26;
	localparam int RT_MSB = 25;
	localparam int RT_LSB = 21;
	localparam int RA_MSB = 20;
	localparam int RA_LSB = 16;
	localparam int RB_MSB = 15;
	localparam int RB_LSB = 11;
	localparam int FN_MSB = 4;
	localparam int FN_LSB = 0;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;
	// jump offset fills everything below the opcode
	localparam int JOFF_MSB = 25;

endpackage
